/* sme.f */
+incdir+hw
+incdir+dv
hw/sme_pkg.sv
hw/sme_load_sequencer.sv
hw/sme_offset_matcher.sv
hw/sme_first_match.sv
hw/sme_top.sv
dv/sme_tb.sv

/* Makefile */
# Verilator build and run for the string matching engine

VERILATOR  ?= verilator
TOP        ?= sme_tb
LINT_TOP   ?= sme_top
FILELIST   ?= sme.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --timescale 1ns/100ps -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/100ps
PASS_TEXT  ?= \*\*\* PASSED \*\*\*

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '$(PASS_TEXT)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/sme_tb_tests.svh */
`ifndef SME_TB_TESTS_SVH
`define SME_TB_TESTS_SVH

// ============================================================
// Reference model
// ============================================================
function automatic logic offset_passes(input int k, output logic skipped);
    int         pos;
    logic       ok;
    logic       in_text;
    logic       on_space;
    logic [7:0] c;
    pos     = k;
    ok      = 1'b1;
    skipped = 1'b0;
    for (int i = 0; i < tb_pat_len; i++)
    begin
        c        = tb_pat[i[2:0]];
        in_text  = pos < tb_text_len;
        on_space = in_text && (tb_text[pos[4:0]] == `SME_SPACE);
        if (c == `SME_HAT)
        begin
            // Hat holds at the start, eats a space elsewhere
            if (pos != 0 && on_space)
            begin
                pos++;
                if (i == 0)
                begin
                    skipped = 1'b1;
                end
            end
            else if (pos != 0)
            begin
                ok = 1'b0;
            end
        end
        else if (c == `SME_DOLLAR)
        begin
            if (pos != tb_text_len && on_space)
            begin
                pos++;
            end
            else if (pos != tb_text_len)
            begin
                ok = 1'b0;
            end
        end
        else if (in_text && (c == `SME_DOT || c == tb_text[pos[4:0]]))
        begin
            pos++;
        end
        else
        begin
            ok = 1'b0;
        end
    end
    return ok;
endfunction

// Lowest passing offset; the index holds when nothing matches
function automatic void run_model(output logic found, output logic [4:0] index);
    logic skipped;
    found = 1'b0;
    index = exp_index;
    for (int k = 0; k < `SME_STR_LEN && !found; k++)
    begin
        if (offset_passes(k, skipped))
        begin
            found = 1'b1;
            index = 5'(k + int'(skipped));
        end
    end
endfunction

// ============================================================
// Stimulus helpers
// ============================================================
function automatic logic [7:0] char_from_code(input int code);
    case (code)
        0, 3:    return 8'h61;
        1, 4:    return 8'h62;
        2:       return `SME_SPACE;
        5:       return `SME_DOT;
        6:       return `SME_HAT;
        default: return `SME_DOLLAR;
    endcase
endfunction

task automatic set_text(input string s);
    tb_text_len = s.len();
    for (int i = 0; i < `SME_STR_LEN; i++)
    begin
        tb_text[i[4:0]] = (i < s.len()) ? s[i] : 8'h00;
    end
endtask

task automatic set_pattern(input string s);
    tb_pat_len = s.len();
    for (int i = 0; i < `SME_PAT_LEN; i++)
    begin
        tb_pat[i[2:0]] = (i < s.len()) ? s[i] : 8'h00;
    end
endtask

// Strobe buffers in, wait for valid and compare with the model
task automatic run_case(input logic send_text, input logic send_pat);
    logic       exp_match;
    logic [4:0] model_index;
    int         cycles;
    if (send_text)
    begin
        for (int i = 0; i < tb_text_len; i++)
        begin
            chardata = tb_text[i[4:0]];
            isstring = 1'b1;
            next_cycle();
            check("valid", 32'(valid), 32'h0);
        end
        isstring = 1'b0;
    end
    if (send_pat)
    begin
        for (int i = 0; i < tb_pat_len; i++)
        begin
            chardata  = tb_pat[i[2:0]];
            ispattern = 1'b1;
            next_cycle();
            check("valid", 32'(valid), 32'h0);
        end
        ispattern = 1'b0;
    end
    chardata = 8'h00;
    cycles   = 0;
    while (valid !== 1'b1 && cycles < VALID_TIMEOUT)
    begin
        next_cycle();
        cycles++;
    end
    if (valid !== 1'b1)
    begin
        error_count++;
        $display("Timeout: valid did not rise within %0d cycles", VALID_TIMEOUT);
    end
    else
    begin
        // Result lands one cycle after the last pattern step
        check("valid_latency", cycles, tb_pat_len + 1);
        run_model(exp_match, model_index);
        exp_index = model_index;
        check("match", 32'(match), 32'(exp_match));
        check("match_index", 32'(match_index), 32'(exp_index));
        next_cycle();
        check("valid", 32'(valid), 32'h0);
    end
endtask

task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before)
    begin
        $display("test %s: ok", name);
    end
    else
    begin
        $display("test %s: %0d errors", name, error_count - errors_before);
    end
endtask

// ============================================================
// Directed tests
// ============================================================
task automatic test_reset();
    int errs;
    errs = error_count;
    check("valid", 32'(valid), 32'h0);
    check("match", 32'(match), 32'h0);
    check("match_index", 32'(match_index), 32'h0);
    finish_test("reset", errs);
endtask

task automatic test_plain();
    int errs;
    errs = error_count;
    set_text("hello world");
    set_pattern("o w");
    run_case(1'b1, 1'b1);
    check("match", 32'(match), 32'h1);
    check("match_index", 32'(match_index), 32'h4);
    set_pattern("xyz");
    run_case(1'b0, 1'b1);
    check("match", 32'(match), 32'h0);
    finish_test("plain", errs);
endtask

task automatic test_dot();
    int errs;
    errs = error_count;
    set_pattern("w.r");
    run_case(1'b0, 1'b1);
    check("match_index", 32'(match_index), 32'h6);
    finish_test("dot", errs);
endtask

task automatic test_anchors();
    int errs;
    errs = error_count;
    set_text("ab cab");
    set_pattern("^ab");
    run_case(1'b1, 1'b1);
    check("match_index", 32'(match_index), 32'h0);
    set_pattern("^ca");
    run_case(1'b0, 1'b1);
    check("match_index", 32'(match_index), 32'h3);
    // Dollar at the very end of the text
    set_pattern("cab$");
    run_case(1'b0, 1'b1);
    check("match_index", 32'(match_index), 32'h3);
    set_pattern("ab$");
    run_case(1'b0, 1'b1);
    set_pattern("b $");
    run_case(1'b0, 1'b1);
    finish_test("anchors", errs);
endtask

task automatic test_reload();
    int errs;
    errs = error_count;
    set_pattern("ab");
    run_case(1'b0, 1'b1);
    set_text("ba ba ab");
    run_case(1'b1, 1'b0);
    set_pattern("^ba");
    run_case(1'b0, 1'b1);
    finish_test("reload", errs);
endtask

task automatic test_random();
    int errs;
    errs = error_count;
    for (int r = 0; r < 20; r++)
    begin
        tb_text_len = 1 + rand_bits(5);
        for (int i = 0; i < `SME_STR_LEN; i++)
        begin
            tb_text[i[4:0]] = (i < tb_text_len) ? char_from_code(rand_bits(2)) : 8'h00;
        end
        tb_pat_len = 1 + rand_bits(3);
        for (int i = 0; i < `SME_PAT_LEN; i++)
        begin
            tb_pat[i[2:0]] = (i < tb_pat_len) ? char_from_code(rand_bits(3)) : 8'h00;
        end
        run_case(1'b1, 1'b1);
    end
    finish_test("random", errs);
endtask

// Full-length pattern stretches MATCH to its longest
task automatic test_timing();
    int errs;
    errs = error_count;
    set_text("abababab ab");
    set_pattern("ab.ab.ab");
    run_case(1'b1, 1'b1);
    finish_test("timing", errs);
endtask

`endif

/* dv/sme_tb.sv */
`include "sme_macros.svh"

module sme_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 10;
    localparam int VALID_TIMEOUT = 40;

    logic        clk;
    logic        reset;
    logic [7:0]  chardata;
    logic        isstring;
    logic        ispattern;
    logic        match;
    logic [4:0]  match_index;
    logic        valid;

    // Expected contents of the DUT buffers
    logic [7:0]  tb_text [`SME_STR_LEN];
    int          tb_text_len;
    logic [7:0]  tb_pat [`SME_PAT_LEN];
    int          tb_pat_len;
    logic [4:0]  exp_index;
    logic [31:0] lfsr_state;
    int          check_count;
    int          error_count;

    sme_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .chardata    (chardata),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .match       (match),
        .match_index (match_index),
        .valid       (valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ============================================================
    // Common helpers
    // ============================================================
    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // Drive point of the next cycle
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    `include "sme_tb_tests.svh"

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        chardata    = 8'h00;
        isstring    = 1'b0;
        ispattern   = 1'b0;
        lfsr_state  = 32'hcd3c;
        exp_index   = 5'd0;
        tb_text_len = 0;
        tb_pat_len  = 0;
        check_count = 0;
        error_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        next_cycle();

        test_reset();
        test_plain();
        test_dot();
        test_anchors();
        test_reload();
        test_random();
        test_timing();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* hw/sme_top.sv */
module sme_top (
    input  logic              clk,
    input  logic              reset,
    input  sme_pkg::char_t    chardata,
    input  logic              isstring,
    input  logic              ispattern,
    output logic              match,
    output sme_pkg::str_idx_t match_index,
    output logic              valid
);
    import sme_pkg::*;

    localparam int NUM_OFFSETS = $bits(offset_mask_t);

    text_t        text;
    str_pos_t     text_len;
    char_t        pat_char;
    logic         step;
    logic         first_step;
    logic         last_step;
    offset_mask_t alive_mask;
    offset_mask_t skip_mask;

    // ============================================================
    // Load and pattern broadcast
    // ============================================================
    sme_load_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .chardata   (chardata),
        .isstring   (isstring),
        .ispattern  (ispattern),
        .text       (text),
        .text_len   (text_len),
        .pat_char   (pat_char),
        .step       (step),
        .first_step (first_step),
        .last_step  (last_step)
    );

    // ============================================================
    // One matcher per text offset
    // ============================================================
    for (genvar k = 0; k < NUM_OFFSETS; k++)
    begin : g_offset
        sme_offset_matcher #(
            .OFFSET (k)
        ) u_matcher (
            .clk        (clk),
            .reset      (reset),
            .text       (text),
            .text_len   (text_len),
            .pat_char   (pat_char),
            .step       (step),
            .first_step (first_step),
            .alive      (alive_mask[k]),
            .skip       (skip_mask[k])
        );
    end

    sme_first_match u_first_match (
        .clk         (clk),
        .reset       (reset),
        .alive       (alive_mask),
        .skip        (skip_mask),
        .last_step   (last_step),
        .match       (match),
        .match_index (match_index),
        .valid       (valid)
    );

endmodule

/* hw/sme_first_match.sv */
`include "sme_macros.svh"

module sme_first_match (
    input  logic                  clk,
    input  logic                  reset,
    input  sme_pkg::offset_mask_t alive,
    input  sme_pkg::offset_mask_t skip,
    input  logic                  last_step,
    output logic                  match,
    output sme_pkg::str_idx_t     match_index,
    output logic                  valid
);
    import sme_pkg::*;

    str_idx_t first_idx;
    logic     any_alive;

    // Lowest set bit wins, so scan from the top down
    always_comb
    begin
        first_idx = '0;
        for (int k = `SME_STR_LEN - 1; k >= 0; k--)
        begin
            if (alive[k])
            begin
                first_idx = str_idx_t'(k);
            end
        end
    end

    assign any_alive = |alive;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            match       <= 1'b0;
            match_index <= '0;
            valid       <= 1'b0;
        end
        else
        begin
            valid <= last_step;
            if (last_step)
            begin
                match <= any_alive;
                // Step past a space eaten by a leading hat
                if (any_alive)
                begin
                    match_index <= first_idx + str_idx_t'(skip[first_idx]);
                end
            end
        end
    end

endmodule

/* hw/sme_offset_matcher.sv */
`include "sme_macros.svh"

module sme_offset_matcher #(
    parameter int OFFSET = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  sme_pkg::text_t    text,
    input  sme_pkg::str_pos_t text_len,
    input  sme_pkg::char_t    pat_char,
    input  logic              step,
    input  logic              first_step,
    output logic              alive,
    output logic              skip
);
    import sme_pkg::*;

    localparam int POS_AW = $clog2(`SME_STR_LEN);

    str_pos_t pos;
    str_pos_t cur_pos;
    char_t    text_char;
    logic     alive_q;
    logic     skip_q;
    logic     cur_alive;
    logic     in_text;
    logic     is_space;
    logic     is_hat;
    logic     pass;
    logic     advance;
    logic     alive_next;
    logic     skip_next;

    // Each run restarts at this cell's own offset
    assign cur_pos   = first_step ? str_pos_t'(OFFSET) : pos;
    assign cur_alive = first_step || alive_q;
    assign in_text   = cur_pos < text_len;
    assign text_char = text[cur_pos[POS_AW-1:0]*`SME_CHAR_W +: `SME_CHAR_W];
    assign is_space  = in_text && (text_char == `SME_SPACE);
    assign is_hat    = (pat_char == `SME_HAT);

    always_comb
    begin
        advance = 1'b1;
        case (pat_char)
            `SME_HAT:
            begin
                // Start of text holds the position, a space is consumed
                pass    = (cur_pos == '0) || is_space;
                advance = (cur_pos != '0);
            end
            `SME_DOLLAR:
            begin
                pass    = (cur_pos == text_len) || is_space;
                advance = (cur_pos != text_len);
            end
            `SME_DOT: pass = in_text;
            default:  pass = in_text && (text_char == pat_char);
        endcase
    end

    assign alive_next = cur_alive && pass;
    assign skip_next  = first_step ? (is_hat && pass && advance) : skip_q;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pos     <= '0;
            alive_q <= 1'b0;
            skip_q  <= 1'b0;
        end
        else if (step)
        begin
            pos     <= advance ? cur_pos + str_pos_t'(1) : cur_pos;
            alive_q <= alive_next;
            skip_q  <= skip_next;
        end
    end

    // Look-ahead so the picker samples the last step's outcome
    assign alive = step ? alive_next : alive_q;
    assign skip  = step ? skip_next : skip_q;

endmodule

/* hw/sme_load_sequencer.sv */
`include "sme_macros.svh"

module sme_load_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  sme_pkg::char_t    chardata,
    input  logic              isstring,
    input  logic              ispattern,
    output sme_pkg::text_t    text,
    output sme_pkg::str_pos_t text_len,
    output sme_pkg::char_t    pat_char,
    output logic              step,
    output logic              first_step,
    output logic              last_step
);
    import sme_pkg::*;

    localparam int POS_AW = $clog2(`SME_STR_LEN);
    localparam int PAT_AW = $clog2(`SME_PAT_LEN);

    phase_t   phase;
    phase_t   phase_next;
    char_t    pattern [`SME_PAT_LEN];
    pat_idx_t pat_len;
    pat_idx_t pat_ptr;
    logic     prev_isstring;
    logic     prev_ispattern;
    logic     loaded;
    logic     str_wr;
    logic     pat_wr;
    logic     new_str_run;
    logic     new_pat_run;
    logic     start_match;

    // ============================================================
    // Load side
    // ============================================================
    assign str_wr      = (phase == LOAD) && isstring;
    assign pat_wr      = (phase == LOAD) && ispattern;
    assign new_str_run = str_wr && !prev_isstring;
    assign new_pat_run = pat_wr && !prev_ispattern;

    // Idle cycle after some load, and a pattern to walk
    assign start_match = (phase == LOAD) && !isstring && !ispattern && loaded
                         && (pat_len != '0);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            prev_isstring  <= 1'b0;
            prev_ispattern <= 1'b0;
            loaded         <= 1'b0;
        end
        else
        begin
            prev_isstring  <= str_wr;
            prev_ispattern <= pat_wr;
            if (start_match)
            begin
                loaded <= 1'b0;
            end
            else if (str_wr || pat_wr)
            begin
                loaded <= 1'b1;
            end
        end
    end

    // New text run zeroes the unwritten bytes
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            text     <= '0;
            text_len <= '0;
        end
        else if (new_str_run)
        begin
            text     <= text_t'(chardata);
            text_len <= str_pos_t'(1);
        end
        else if (str_wr && (text_len < str_pos_t'(`SME_STR_LEN)))
        begin
            text[text_len[POS_AW-1:0]*`SME_CHAR_W +: `SME_CHAR_W] <= chardata;
            text_len <= text_len + str_pos_t'(1);
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pat_len <= '0;
        end
        else if (new_pat_run)
        begin
            pat_len <= pat_idx_t'(1);
        end
        else if (pat_wr && (pat_len < pat_idx_t'(`SME_PAT_LEN)))
        begin
            pat_len <= pat_len + pat_idx_t'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (new_pat_run)
        begin
            pattern[0] <= chardata;
        end
        else if (pat_wr && (pat_len < pat_idx_t'(`SME_PAT_LEN)))
        begin
            pattern[pat_len[PAT_AW-1:0]] <= chardata;
        end
    end

    // ============================================================
    // Phase FSM and pattern walk
    // ============================================================
    always_comb
    begin
        phase_next = phase;
        case (phase)
            LOAD:    phase_next = start_match ? MATCH : LOAD;
            MATCH:   phase_next = last_step ? DONE : MATCH;
            DONE:    phase_next = LOAD;
            default: phase_next = LOAD;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            phase   <= LOAD;
            pat_ptr <= '0;
        end
        else
        begin
            phase <= phase_next;
            if (step)
            begin
                pat_ptr <= last_step ? '0 : pat_ptr + pat_idx_t'(1);
            end
        end
    end

    // One pattern character per MATCH cycle
    assign step       = (phase == MATCH);
    assign first_step = step && (pat_ptr == '0);
    assign last_step  = step && (pat_ptr == pat_len - pat_idx_t'(1));
    assign pat_char   = pattern[pat_ptr[PAT_AW-1:0]];

endmodule

/* hw/sme_pkg.sv */
`include "sme_macros.svh"

package sme_pkg;

    // One character
    typedef logic [`SME_CHAR_W-1:0] char_t;

    // Whole text, position 0 in the low byte
    typedef logic [`SME_STR_LEN*`SME_CHAR_W-1:0] text_t;

    // Text position or length, must hold the full length
    typedef logic [$clog2(`SME_STR_LEN+1)-1:0] str_pos_t;
    typedef logic [$clog2(`SME_STR_LEN)-1:0] str_idx_t;

    // Pattern position or length
    typedef logic [$clog2(`SME_PAT_LEN+1)-1:0] pat_idx_t;

    typedef logic [`SME_STR_LEN-1:0] offset_mask_t;

    typedef enum logic [1:0] {LOAD, MATCH, DONE} phase_t;

endpackage

/* hw/sme_macros.svh */
`ifndef SME_MACROS_SVH
`define SME_MACROS_SVH

// Character width and buffer capacities
`define SME_CHAR_W   8
`define SME_STR_LEN  32
`define SME_PAT_LEN  8

// Pattern control characters
`define SME_HAT      8'h5E
`define SME_DOLLAR   8'h24
`define SME_DOT      8'h2E

// Word separator in the text
`define SME_SPACE    8'h20

`endif
